/* Makefile */
# Verilator build, run and lint for the prefetch subsystem
VERILATOR ?= verilator
TOP       ?= prefetch_tb
FILELIST  ?= prefetch.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --assert --timing
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= All tests passed!

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(wildcard design/*.sv bench/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* bench/fetch_mem_model.sv */
/*
 * Bus-side memory model for the prefetch testbench
 * Seeded program image with error words, random grant and response delays
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_mem_model #(
  parameter int unsigned SEED = 32'h97d1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             err_en_i,
  input  logic             req_i,
  input  fetch_pkg::addr_t addr_i,
  output logic             gnt_o,
  output logic             rvalid_o,
  output fetch_pkg::word_t rdata_o,
  output logic             err_o
);

  import fetch_pkg::*;

  localparam int unsigned MEM_WORDS = 256;

  word_t       mem     [MEM_WORDS];
  logic        err_mem [MEM_WORDS];
  integer      seed;
  int unsigned cycle;
  int unsigned gnt_wait;
  int unsigned gnt_target;
  int unsigned last_due;
  int unsigned due;
  logic        waiting;
  logic        accept_seen;
  logic [7:0]  accept_idx;
  logic [7:0]  idx;
  logic [7:0]  idx_q [$];
  int unsigned due_q [$];

  // Program image, roughly one word in sixteen answers with an error
  initial begin
    seed     = SEED;
    cycle    = 0;
    last_due = 0;
    waiting  = 1'b0;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = $random(seed);
      err_mem[i] = (($random(seed) & 15) == 0);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus timing
  //////////////////////////////////////////////////////////////////////

  always begin
    // Grant that takes effect on the coming edge
    @(negedge clk_i);
    accept_seen = rst_ni & req_i & gnt_o;
    accept_idx  = addr_i[9:2];
    @(posedge clk_i);
    #1;
    if (!rst_ni) begin
      waiting  = 1'b0;
      gnt_o    = 1'b0;
      rvalid_o = 1'b0;
      rdata_o  = '0;
      err_o    = 1'b0;
      idx_q.delete();
      due_q.delete();
      last_due = cycle;
    end else begin
      cycle++;
      // Response 1 to 3 cycles after the grant, always behind the previous one
      if (accept_seen) begin
        due = cycle + ($unsigned($random(seed)) % 3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        idx_q.push_back(accept_idx);
        due_q.push_back(due);
      end
      // Grant after 0 to 2 waiting cycles
      if (req_i) begin
        if (!waiting) begin
          waiting    = 1'b1;
          gnt_wait   = 0;
          gnt_target = $unsigned($random(seed)) % 3;
        end
        gnt_o = (gnt_wait == gnt_target);
        if (gnt_o) begin
          waiting = 1'b0;
        end else begin
          gnt_wait++;
        end
      end else begin
        waiting = 1'b0;
        gnt_o   = 1'b0;
      end
      // In-order response strobe
      if (due_q.size() != 0 && due_q[0] == cycle) begin
        due      = due_q.pop_front();
        idx      = idx_q.pop_front();
        rvalid_o = 1'b1;
        rdata_o  = mem[idx];
        err_o    = err_en_i & err_mem[idx];
      end else begin
        rvalid_o = 1'b0;
        rdata_o  = '0;
        err_o    = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* bench/prefetch_tb.sv */
/*
 * Testbench for the instruction prefetch subsystem
 * Clock, reset, random back-pressure and branches, reference model, checks
 */

`timescale 1ns/1ps
`default_nettype none

module prefetch_tb;

  import fetch_pkg::*;

  localparam int unsigned SEED         = 32'h97d1;
  localparam int unsigned XFER_TIMEOUT = 5000;
  localparam int unsigned VALID_WAIT   = 100;

  logic  clk_i;
  logic  rst_ni;
  logic  branch_i;
  addr_t branch_addr_i;
  logic  ready_i;
  logic  valid_o;
  word_t rdata_o;
  addr_t addr_o;
  logic  err_o;
  logic  err_plus2_o;
  logic  req_o;
  addr_t bus_addr_o;
  logic  gnt_i;
  logic  rvalid_i;
  word_t rdata_i;
  logic  err_i;
  logic  err_en;

  integer      seed;
  int unsigned errors;
  int unsigned tests_run;
  int unsigned tests_failed;
  string       test_name;

  // Reference model state
  addr_t model_pc;
  addr_t fetch_pc;
  logic  model_on;
  logic  model_err_on;
  logic  hold_pending;
  int    in_flight;

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  prefetch_top i_prefetch_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .ready_i       (ready_i),
    .valid_o       (valid_o),
    .rdata_o       (rdata_o),
    .addr_o        (addr_o),
    .err_o         (err_o),
    .err_plus2_o   (err_plus2_o),
    .req_o         (req_o),
    .bus_addr_o    (bus_addr_o),
    .gnt_i         (gnt_i),
    .rvalid_i      (rvalid_i),
    .rdata_i       (rdata_i),
    .err_i         (err_i)
  );

  fetch_mem_model #(.SEED(SEED)) i_fetch_mem_model (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .err_en_i (err_en),
    .req_i    (req_o),
    .addr_i   (bus_addr_o),
    .gnt_o    (gnt_i),
    .rvalid_o (rvalid_i),
    .rdata_o  (rdata_i),
    .err_o    (err_i)
  );

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (exp !== act) begin
      errors++;
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_addr(input string what, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      errors++;
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference instruction model
  //////////////////////////////////////////////////////////////////////

  // Expected instruction at pc, mask keeps only the bits that belong to it
  function automatic void model_instr(input addr_t pc, input logic err_on,
                                      output word_t data, output word_t mask,
                                      output logic err, output logic plus2,
                                      output addr_t step);
    logic [7:0] idx;
    logic [7:0] idx_next;
    word_t      w0;
    word_t      w1;
    logic       e0;
    logic       e1;
    logic       comp;
    idx      = pc[9:2];
    idx_next = idx + 8'd1;
    w0       = i_fetch_mem_model.mem[idx];
    w1       = i_fetch_mem_model.mem[idx_next];
    e0       = err_on & i_fetch_mem_model.err_mem[idx];
    e1       = err_on & i_fetch_mem_model.err_mem[idx_next];
    if (!pc[1]) begin
      // Aligned error word is taken as 32-bit
      data  = w0;
      comp  = (w0[1:0] != 2'b11) && !e0;
      err   = e0;
      plus2 = 1'b0;
    end else begin
      // Unaligned start in an error word is taken as 16-bit
      data  = {w1[15:0], w0[31:16]};
      comp  = (w0[17:16] != 2'b11) || e0;
      err   = comp ? e0 : (e0 | e1);
      plus2 = !comp && e1 && !e0;
    end
    mask = comp ? 32'h0000_ffff : 32'hffff_ffff;
    step = comp ? addr_t'(2) : addr_t'(4);
  endfunction

  function automatic addr_t pick_branch_addr();
    return addr_t'($unsigned($random(seed)) & 32'h0000_03fe);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Cycle driver and monitor
  //////////////////////////////////////////////////////////////////////

  // Outputs are stable at the falling edge, the transfer lands on the next rise
  task automatic sample_cycle(output logic xfer);
    word_t exp_data;
    word_t exp_mask;
    logic  exp_err;
    logic  exp_plus2;
    addr_t step;
    int    busy_cnt;
    xfer = 1'b0;
    step = '0;
    @(negedge clk_i);
    busy_cnt = $countones(i_prefetch_top.fifo_busy);
    if (in_flight + busy_cnt > int'(NUM_REQS)) begin
      errors++;
      $display("%s: %0d fetches in flight plus %0d buffered words exceed the limit",
               test_name, in_flight, busy_cnt);
    end
    if (req_o && gnt_i) in_flight++;
    if (rvalid_i) in_flight--;
    if (!model_on) begin
      check_flag("valid_o before first branch", 1'b0, valid_o);
      check_flag("req_o before first branch", 1'b0, req_o);
    end else begin
      // Word fetches run from the aligned branch target
      if (req_o) begin
        check_addr("bus_addr_o", fetch_pc, bus_addr_o);
      end
      if (hold_pending && !valid_o) begin
        errors++;
        $display("%s: valid_o fell at %h before the transfer", test_name, model_pc);
      end
      if (valid_o) begin
        model_instr(model_pc, model_err_on, exp_data, exp_mask, exp_err, exp_plus2, step);
        check_addr("addr_o", model_pc, addr_o);
        check_flag("err_o", exp_err, err_o);
        check_flag("err_plus2_o", exp_plus2, err_plus2_o);
        // Data under an error carries no meaning
        if (!exp_err) begin
          check_word("rdata_o", exp_data & exp_mask, rdata_o & exp_mask);
        end
      end
      if (valid_o && ready_i && !branch_i) begin
        model_pc = model_pc + step;
        xfer     = 1'b1;
      end
    end
    hold_pending = valid_o && !ready_i && !branch_i;
    // Redirect wins over a transfer in the same cycle
    if (branch_i) begin
      model_pc     = branch_addr_i;
      fetch_pc     = {branch_addr_i[31:2], 2'b00};
      model_on     = 1'b1;
      model_err_on = err_en;
    end else if (req_o && gnt_i) begin
      fetch_pc = fetch_pc + addr_t'(4);
    end
  endtask

  task automatic drive_cycle(input logic ready, input logic branch, input addr_t baddr,
                             output logic xfer);
    @(posedge clk_i);
    #1;
    ready_i       = ready;
    branch_i      = branch;
    branch_addr_i = branch ? baddr : '0;
    sample_cycle(xfer);
  endtask

  task automatic report_test(input int unsigned start_err, input int unsigned xfers);
    tests_run++;
    if (errors != start_err) tests_failed++;
    $display("%-14s %4d transfers, %0d errors", test_name, xfers, errors - start_err);
  endtask

  // Random ready and branches until enough transfers were seen
  task automatic run_test(input string name, input int unsigned n_xfers,
                          input int unsigned ready_pct, input int unsigned branch_pct);
    int unsigned start_err;
    int unsigned got;
    int unsigned cycles;
    logic        rdy;
    logic        br;
    logic        xfer;
    test_name = name;
    start_err = errors;
    got       = 0;
    cycles    = 0;
    while (got < n_xfers && cycles < XFER_TIMEOUT) begin
      rdy = ($unsigned($random(seed)) % 100) < ready_pct;
      br  = ($unsigned($random(seed)) % 100) < branch_pct;
      drive_cycle(rdy, br, pick_branch_addr(), xfer);
      if (xfer) got++;
      cycles++;
    end
    if (got < n_xfers) begin
      errors++;
      $display("%s: timed out after %0d cycles with %0d of %0d transfers",
               name, cycles, got, n_xfers);
    end
    report_test(start_err, got);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned start_err;
    int unsigned waited;
    addr_t       first_addr;
    logic        xfer;
    seed          = SEED;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_name     = "reset";
    rst_ni        = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    ready_i       = 1'b0;
    err_en        = 1'b0;
    model_pc      = '0;
    fetch_pc      = '0;
    model_on      = 1'b0;
    model_err_on  = 1'b0;
    hold_pending  = 1'b0;
    in_flight     = 0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Quiet until the first branch, then the stream starts at its address
    test_name = "reset_idle";
    start_err = errors;
    for (int i = 0; i < 10; i++) begin
      drive_cycle(1'b1, 1'b0, '0, xfer);
    end
    first_addr = pick_branch_addr();
    drive_cycle(1'b0, 1'b1, first_addr, xfer);
    waited = 0;
    while (!valid_o && waited < VALID_WAIT) begin
      drive_cycle(1'b0, 1'b0, '0, xfer);
      waited++;
    end
    if (!valid_o) begin
      errors++;
      $display("reset_idle: no valid_o within %0d cycles of the first branch", VALID_WAIT);
    end
    check_addr("first addr_o", first_addr, addr_o);
    report_test(start_err, 0);

    run_test("ready_stream", 300, 100, 0);
    run_test("back_pressure", 300, 50, 0);
    run_test("branch_flush", 300, 70, 4);

    // Error words come on together with a flush, no clean word stays queued
    err_en = 1'b1;
    drive_cycle(1'b1, 1'b1, pick_branch_addr(), xfer);
    run_test("error_marking", 400, 70, 2);

    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/fetch_fifo.sv */
/*
 * Fetch FIFO with input bypass and compressed-instruction aligner
 * Instruction address register, split-instruction error marking
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_fifo (
  input  logic                           clk_i,
  input  logic                           rst_ni,

  // Flush and restart address
  input  logic                           clear_i,
  input  fetch_pkg::addr_t               clear_addr_i,
  output logic [fetch_pkg::NUM_REQS-1:0] busy_o,

  // Words from the bus
  input  logic                           in_valid_i,
  input  fetch_pkg::word_t               in_rdata_i,
  input  logic                           in_err_i,

  // Instructions to the core
  output logic                           out_valid_o,
  input  logic                           out_ready_i,
  output fetch_pkg::addr_t               out_addr_o,
  output fetch_pkg::word_t               out_rdata_o,
  output logic                           out_err_o,
  output logic                           out_err_plus2_o
);

  import fetch_pkg::*;

  // Entry 0 is the oldest word and feeds the output
  word_t [FIFO_DEPTH-1:0] rdata_q, rdata_d, rdata_above;
  logic  [FIFO_DEPTH-1:0] err_q, err_d, err_above;
  logic  [FIFO_DEPTH-1:0] valid_q, valid_d, valid_above;
  logic  [FIFO_DEPTH-1:0] free_slot;
  logic  [FIFO_DEPTH-1:0] filled, filled_above;
  logic  [FIFO_DEPTH-1:0] entry_en;

  logic  pop;
  logic  unaligned;
  logic  step_two;
  logic  aligned_c, unaligned_c;

  word_t head_rdata, split_rdata;
  logic  head_err, head_valid;
  logic  split_err, split_plus2, split_valid;

  addr_t instr_addr_q, instr_addr_d;
  logic  instr_addr_en;

  //////////////////////////////////////////////////////////////////////
  // Head word with bypass
  //////////////////////////////////////////////////////////////////////

  // Empty FIFO hands the bus word straight through
  assign head_rdata = valid_q[0] ? rdata_q[0] : in_rdata_i;
  assign head_err   = valid_q[0] ? err_q[0]   : in_err_i;
  assign head_valid = valid_q[0] | in_valid_i;

  // Size decode, data under an error is meaningless
  // Aligned error word counts as 32-bit, unaligned error start as 16-bit
  assign aligned_c   = (head_rdata[1:0] != 2'b11) & ~head_err;
  assign unaligned_c = (head_rdata[17:16] != 2'b11) | head_err;

  //////////////////////////////////////////////////////////////////////
  // Aligner
  //////////////////////////////////////////////////////////////////////

  // Upper half of the head word plus lower half of the next word
  // Next word comes from entry 1 or from the bus
  assign split_rdata = valid_q[1] ? {rdata_q[1][15:0], head_rdata[31:16]} :
                                    {in_rdata_i[15:0], head_rdata[31:16]};

  // Second word only matters when the instruction really is 32-bit
  assign split_err = valid_q[1] ?
                     (err_q[0] | (err_q[1] & ~unaligned_c)) :
                     ((valid_q[0] & err_q[0]) |
                      (in_err_i & (~valid_q[0] | ~unaligned_c)));

  // Error sits only in the second word of a split instruction
  assign split_plus2 = ~unaligned_c &
                       (valid_q[1] ? (err_q[1] & ~err_q[0]) :
                                     (valid_q[0] & in_err_i & ~err_q[0]));

  // Both halves must be present
  assign split_valid = valid_q[1] | (valid_q[0] & in_valid_i);

  assign unaligned = instr_addr_q[1];

  always_comb begin
    if (unaligned) begin
      out_rdata_o     = split_rdata;
      out_err_o       = split_err;
      out_err_plus2_o = split_plus2;
      // Compressed one fits in the head word alone
      out_valid_o     = unaligned_c ? head_valid : split_valid;
    end else begin
      out_rdata_o     = head_rdata;
      out_err_o       = head_err;
      out_err_plus2_o = 1'b0;
      out_valid_o     = head_valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Instruction address
  //////////////////////////////////////////////////////////////////////

  assign step_two      = unaligned ? unaligned_c : aligned_c;
  assign instr_addr_en = clear_i | (out_valid_o & out_ready_i);
  assign instr_addr_d  = clear_i ? clear_addr_i :
                         instr_addr_q + (step_two ? addr_t'(2) : addr_t'(4));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_addr_q <= '0;
    end else if (instr_addr_en) begin
      instr_addr_q <= instr_addr_d;
    end
  end

  assign out_addr_o = instr_addr_q;

  //////////////////////////////////////////////////////////////////////
  // Entry management
  //////////////////////////////////////////////////////////////////////

  // Head word leaves once its upper half is consumed
  // A 16-bit instruction in the lower half leaves the word in place
  assign pop = out_valid_o & out_ready_i & (unaligned | ~aligned_c);

  // Only the upper entries limit new bus requests
  assign busy_o = valid_q[FIFO_DEPTH-1:FIFO_DEPTH-NUM_REQS];

  // Write pointer, first empty entry above the filled ones
  assign free_slot[0] = ~valid_q[0];
  for (genvar i = 1; i < FIFO_DEPTH; i++) begin : g_free
    assign free_slot[i] = ~valid_q[i] & valid_q[i-1];
  end

  // Occupancy after the push, before the shift
  assign filled = valid_q | ({FIFO_DEPTH{in_valid_i}} & free_slot);

  // Neighbour above each entry, nothing above the top one
  assign filled_above = {1'b0, filled[FIFO_DEPTH-1:1]};
  assign valid_above  = {1'b0, valid_q[FIFO_DEPTH-1:1]};
  assign err_above    = {1'b0, err_q[FIFO_DEPTH-1:1]};
  assign rdata_above  = {32'h0, rdata_q[FIFO_DEPTH-1:1]};

  // Clear also wipes a word arriving in the same cycle
  assign valid_d = ~{FIFO_DEPTH{clear_i}} & (pop ? filled_above : filled);

  // Shift down on pop, else load the bus word into the free slot
  assign entry_en = ({FIFO_DEPTH{pop}} & filled_above) |
                    ({FIFO_DEPTH{in_valid_i & ~pop}} & free_slot);

  for (genvar i = 0; i < FIFO_DEPTH; i++) begin : g_next
    assign rdata_d[i] = valid_above[i] ? rdata_above[i] : in_rdata_i;
    assign err_d[i]   = valid_above[i] ? err_above[i]   : in_err_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // Entry payload, loaded on push or shift
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      if (entry_en[i]) begin
        rdata_q[i] <= rdata_d[i];
        err_q[i]   <= err_d[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Controller must stop requesting before the top entry fills
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_valid_i && !pop) |-> !valid_q[FIFO_DEPTH-1]);

  // Shift and load in one cycle also needs room at the top
  a_no_push_pop_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_valid_i && pop) |-> !valid_q[FIFO_DEPTH-1]);

endmodule

`default_nettype wire

/* design/fetch_pkg.sv */
/*
 * Shared constants and types for the instruction prefetch subsystem
 * Fetch depth limits, word, address and counter types
 */

`default_nettype none

package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // Depth constants
  //////////////////////////////////////////////////////////////////////

  // Most fetches in flight plus buffered in the upper FIFO entries
  localparam int unsigned NUM_REQS = 2;

  // Entry 0 feeds the output, the upper entries match NUM_REQS
  localparam int unsigned FIFO_DEPTH = NUM_REQS + 1;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // One word as returned by the memory bus
  typedef logic [31:0] word_t;

  // Byte address, instruction addresses are half-word aligned
  typedef logic [31:0] addr_t;

  // Holds 0 to NUM_REQS
  typedef logic [$clog2(NUM_REQS + 1)-1:0] ptr_t;

endpackage

`default_nettype wire

/* design/fetch_req_ctrl.sv */
/*
 * Bus request controller for the prefetch subsystem
 * Fetch address register, outstanding and discard counters, push to FIFO
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_req_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_ni,

  // Core redirect
  input  logic                           branch_i,
  input  fetch_pkg::addr_t               branch_addr_i,

  // Fill state of the upper FIFO entries
  input  logic [fetch_pkg::NUM_REQS-1:0] busy_i,

  // Memory bus
  output logic                           req_o,
  output fetch_pkg::addr_t               bus_addr_o,
  input  logic                           gnt_i,
  input  logic                           rvalid_i,
  input  fetch_pkg::word_t               rdata_i,
  input  logic                           err_i,

  // FIFO write side
  output logic                           push_o,
  output fetch_pkg::word_t               push_data_o,
  output logic                           push_err_o,
  output logic                           clear_o,
  output fetch_pkg::addr_t               clear_addr_o
);

  import fetch_pkg::*;

  addr_t                 fetch_addr_q;
  ptr_t                  outstanding_q, outstanding_d;
  ptr_t                  discard_q, discard_d;
  ptr_t                  busy_cnt;
  logic [$bits(ptr_t):0] in_use;
  logic                  fetch_en_q;
  logic                  accept;
  logic                  drop;

  //////////////////////////////////////////////////////////////////////
  // Request issue
  //////////////////////////////////////////////////////////////////////

  // Number of upper FIFO entries holding data
  always_comb begin
    busy_cnt = '0;
    for (int i = 0; i < NUM_REQS; i++) begin
      busy_cnt = busy_cnt + ptr_t'(busy_i[i]);
    end
  end

  // Words that already own a slot, in flight or buffered
  assign in_use = {1'b0, outstanding_q} + {1'b0, busy_cnt};

  // Nothing is fetched until the first branch gives a start address
  // The sum can only shrink while a request waits, so req_o holds
  assign req_o  = fetch_en_q & (in_use < NUM_REQS);
  assign accept = req_o & gnt_i;

  assign bus_addr_o = fetch_addr_q;

  // Branch wins over the step, an old grant in the same cycle is stale
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
      fetch_en_q   <= 1'b0;
    end else if (branch_i) begin
      fetch_addr_q <= {branch_addr_i[31:2], 2'b00};
      fetch_en_q   <= 1'b1;
    end else if (accept) begin
      fetch_addr_q <= fetch_addr_q + addr_t'(4);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response tracking
  //////////////////////////////////////////////////////////////////////

  // Granted minus returned
  assign outstanding_d = outstanding_q + ptr_t'(accept) - ptr_t'(rvalid_i);

  // Response belongs to a fetch from before a branch
  assign drop = rvalid_i & (discard_q != '0);

  // Every request still open after a branch edge is stale
  always_comb begin
    discard_d = discard_q;
    if (branch_i) begin
      discard_d = outstanding_d;
    end else if (drop) begin
      discard_d = discard_q - ptr_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
      discard_q     <= '0;
    end else begin
      outstanding_q <= outstanding_d;
      discard_q     <= discard_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // FIFO write side
  //////////////////////////////////////////////////////////////////////

  // No push in the branch cycle, the clear would drop it anyway
  // and the bypass would show stale data to the core
  assign push_o      = rvalid_i & ~drop & ~branch_i;
  assign push_data_o = rdata_i;
  assign push_err_o  = err_i;

  // FIFO empties and reloads its address on the same edge
  assign clear_o      = branch_i;
  assign clear_addr_o = branch_addr_i;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Bus only answers requests that were granted
  a_rvalid_needs_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> (outstanding_q != '0));

  // FIFO busy feedback keeps the bus window bounded
  a_outstanding_max : assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding_q <= NUM_REQS);

  // Waiting request keeps its address until granted, a branch may move it
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_o && !gnt_i && !branch_i) |=> (req_o && $stable(bus_addr_o)));

endmodule

`default_nettype wire

/* design/prefetch_top.sv */
/*
 * Prefetch subsystem top level
 * Request controller feeding the fetch FIFO
 */

`timescale 1ns/1ps
`default_nettype none

module prefetch_top (
  input  logic             clk_i,
  input  logic             rst_ni,

  // Core side
  input  logic             branch_i,
  input  fetch_pkg::addr_t branch_addr_i,
  input  logic             ready_i,
  output logic             valid_o,
  output fetch_pkg::word_t rdata_o,
  output fetch_pkg::addr_t addr_o,
  output logic             err_o,
  output logic             err_plus2_o,

  // Memory bus side
  output logic             req_o,
  output fetch_pkg::addr_t bus_addr_o,
  input  logic             gnt_i,
  input  logic             rvalid_i,
  input  fetch_pkg::word_t rdata_i,
  input  logic             err_i
);

  import fetch_pkg::*;

  // Controller to FIFO
  logic                fifo_push;
  word_t               fifo_wdata;
  logic                fifo_werr;
  logic                fifo_clear;
  addr_t               clr_addr;
  // FIFO back to controller
  logic [NUM_REQS-1:0] fifo_busy;

  fetch_req_ctrl i_fetch_req_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .busy_i        (fifo_busy),
    .req_o         (req_o),
    .bus_addr_o    (bus_addr_o),
    .gnt_i         (gnt_i),
    .rvalid_i      (rvalid_i),
    .rdata_i       (rdata_i),
    .err_i         (err_i),
    .push_o        (fifo_push),
    .push_data_o   (fifo_wdata),
    .push_err_o    (fifo_werr),
    .clear_o       (fifo_clear),
    .clear_addr_o  (clr_addr)
  );

  fetch_fifo i_fetch_fifo (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clear_i         (fifo_clear),
    .clear_addr_i    (clr_addr),
    .busy_o          (fifo_busy),
    .in_valid_i      (fifo_push),
    .in_rdata_i      (fifo_wdata),
    .in_err_i        (fifo_werr),
    .out_valid_o     (valid_o),
    .out_ready_i     (ready_i),
    .out_addr_o      (addr_o),
    .out_rdata_o     (rdata_o),
    .out_err_o       (err_o),
    .out_err_plus2_o (err_plus2_o)
  );

endmodule

`default_nettype wire

/* prefetch.f */
design/fetch_pkg.sv
design/fetch_req_ctrl.sv
design/fetch_fifo.sv
design/prefetch_top.sv
bench/fetch_mem_model.sv
bench/prefetch_tb.sv
